//--- common/csr_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, CSR addresses, constant register values and bus structs
// for the machine-mode CSR file. Referenced through scoped csr_pkg:: names
////////////////////////////////////////////////////////////////////////////

package csr_pkg;

  localparam int XLEN = 32;                // Register width

  typedef logic [XLEN-1:0] xlen_t;         // CSR data
  typedef logic [11:0]     csr_idx_t;      // CSR index

  // Machine-mode CSR addresses
  localparam csr_idx_t CSR_MSTATUS     = 12'h300;
  localparam csr_idx_t CSR_MISA        = 12'h301;
  localparam csr_idx_t CSR_MIE         = 12'h304;
  localparam csr_idx_t CSR_MTVEC       = 12'h305;
  localparam csr_idx_t CSR_MSCRATCH    = 12'h340;
  localparam csr_idx_t CSR_MEPC        = 12'h341;
  localparam csr_idx_t CSR_MCAUSE      = 12'h342;
  localparam csr_idx_t CSR_MIP         = 12'h344;
  localparam csr_idx_t CSR_MCYCLE      = 12'hB00;
  localparam csr_idx_t CSR_MINSTRET    = 12'hB02;
  localparam csr_idx_t CSR_MCYCLEH     = 12'hB80;
  localparam csr_idx_t CSR_MINSTRETH   = 12'hB82;
  localparam csr_idx_t CSR_COUNTERSTOP = 12'hBFF;  // Custom, outside the ISA map
  localparam csr_idx_t CSR_MVENDORID   = 12'hF11;
  localparam csr_idx_t CSR_MARCHID     = 12'hF12;
  localparam csr_idx_t CSR_MIMPID      = 12'hF13;
  localparam csr_idx_t CSR_MHARTID     = 12'hF14;

  // Bit positions in mstatus, mie and mip
  localparam int MIE_BIT  = 3;
  localparam int MPIE_BIT = 7;
  localparam int MEI_BIT  = 11;
  localparam int MTI_BIT  = 7;
  localparam int MSI_BIT  = 3;

  // Read-only identification values, MXL=1 with I, M and C
  localparam xlen_t MISA_VAL      = 32'h4000_1104;
  localparam xlen_t MVENDORID_VAL = 32'h0000_0536;
  localparam xlen_t MARCHID_VAL   = 32'h0000_E203;
  localparam xlen_t MIMPID_VAL    = 32'h0000_0001;

  // CSR access request from the execute stage
  typedef struct packed {
    logic     ena;      // Access valid
    logic     wr_en;    // Write back
    logic     rd_en;    // Read out
    csr_idx_t idx;
  } csr_req_t;

  // Commit side events
  typedef struct packed {
    logic  trap_ena;    // Trap entry, updates mstatus
    logic  mret_ena;
    logic  epc_ena;
    xlen_t epc;
    logic  cause_ena;
    xlen_t cause;
    logic  instret_ena; // One instruction retired
  } cmt_t;

  // Interrupt lines
  typedef struct packed {
    logic ext;
    logic sft;
    logic tmr;
  } irq_t;

  // One flag per implemented CSR, used for read selects and write strobes
  typedef struct packed {
    logic mstatus;
    logic misa;
    logic mie;
    logic mtvec;
    logic mscratch;
    logic mepc;
    logic mcause;
    logic mip;
    logic mcycle;
    logic mcycleh;
    logic minstret;
    logic minstreth;
    logic counterstop;
    logic mvendorid;
    logic marchid;
    logic mimpid;
    logic mhartid;
  } csr_sel_t;

endpackage

//--- csr/csr_counters.sv
////////////////////////////////////////////////////////////////////////////
// 64-bit cycle and retired-instruction counters built from 32-bit halves
// with carry, plus the custom counterstop register
////////////////////////////////////////////////////////////////////////////

module csr_counters (
  input  logic              clk,
  input  logic              reset,
  input  csr_pkg::csr_sel_t wr_stb,
  input  csr_pkg::xlen_t    wdata,
  input  logic              instret_ena,    // Retire pulse from commit
  output csr_pkg::xlen_t    mcycle,
  output csr_pkg::xlen_t    mcycleh,
  output csr_pkg::xlen_t    minstret,
  output csr_pkg::xlen_t    minstreth,
  output csr_pkg::xlen_t    counterstop
);

  // Index 0 is the cycle counter, index 1 the instret counter
  csr_pkg::xlen_t [1:0] lo_q;
  csr_pkg::xlen_t [1:0] hi_q;
  logic [1:0]           tick;     // Count event
  logic [1:0]           stop;     // Counter frozen by counterstop
  logic [1:0]           inc;      // Low half increments
  logic [1:0]           carry;    // Low half wraps this edge
  logic [1:0]           wr_lo;
  logic [1:0]           wr_hi;
  logic [2:0]           cstop_q;  // {IR, TM, CY}

  assign tick  = {instret_ena, 1'b1};
  assign stop  = {cstop_q[2], cstop_q[0]};
  assign wr_lo = {wr_stb.minstret, wr_stb.mcycle};
  assign wr_hi = {wr_stb.minstreth, wr_stb.mcycleh};
  assign inc   = tick & ~stop;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      carry[i] = inc[i] & (lo_q[i] == '1);  // Wrap from all-ones
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Counter halves, software write replaces the count

  always_ff @(posedge clk) begin
    if (reset) begin
      lo_q <= '0;
      hi_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (wr_lo[i]) begin
          lo_q[i] <= wdata;
        end else if (inc[i]) begin
          lo_q[i] <= lo_q[i] + 1'b1;
        end
        if (wr_hi[i]) begin
          hi_q[i] <= wdata;
        end else if (carry[i]) begin
          hi_q[i] <= hi_q[i] + 1'b1;   // Carry from old low value
        end
      end
    end
  end

  // Only the low 3 bits are implemented
  always_ff @(posedge clk) begin
    if (reset) begin
      cstop_q <= '0;
    end else if (wr_stb.counterstop) begin
      cstop_q <= wdata[2:0];
    end
  end

  assign mcycle      = lo_q[0];
  assign mcycleh     = hi_q[0];
  assign minstret    = lo_q[1];
  assign minstreth   = hi_q[1];
  assign counterstop = {{(csr_pkg::XLEN-3){1'b0}}, cstop_q};

endmodule

//--- csr/csr_decode.sv
////////////////////////////////////////////////////////////////////////////
// CSR index decoder. Turns one access request into per-register read
// selects and write strobes, both gated by the request enables
////////////////////////////////////////////////////////////////////////////

module csr_decode (
  input  csr_pkg::csr_req_t req,
  output csr_pkg::csr_sel_t rd_sel,   // Read select per CSR
  output csr_pkg::csr_sel_t wr_stb    // Write strobe per CSR
);

  localparam int SEL_W = $bits(csr_pkg::csr_sel_t);

  csr_pkg::csr_sel_t hit;   // Raw index match, not yet qualified
  logic              rd_go; // Qualified read access
  logic              wr_go; // Qualified write access

  // Only toggle the selects on a real access to save power
  assign rd_go = req.ena & req.rd_en;
  assign wr_go = req.ena & req.wr_en;

  //////////////////////////////////////////////////////////////////////////
  // Address compare

  always_comb begin
    hit             = '0;
    // Trap setup and handling
    hit.mstatus     = (req.idx == csr_pkg::CSR_MSTATUS);
    hit.misa        = (req.idx == csr_pkg::CSR_MISA);
    hit.mie         = (req.idx == csr_pkg::CSR_MIE);
    hit.mtvec       = (req.idx == csr_pkg::CSR_MTVEC);
    hit.mscratch    = (req.idx == csr_pkg::CSR_MSCRATCH);
    hit.mepc        = (req.idx == csr_pkg::CSR_MEPC);
    hit.mcause      = (req.idx == csr_pkg::CSR_MCAUSE);
    hit.mip         = (req.idx == csr_pkg::CSR_MIP);
    // Counters
    hit.mcycle      = (req.idx == csr_pkg::CSR_MCYCLE);
    hit.mcycleh     = (req.idx == csr_pkg::CSR_MCYCLEH);
    hit.minstret    = (req.idx == csr_pkg::CSR_MINSTRET);
    hit.minstreth   = (req.idx == csr_pkg::CSR_MINSTRETH);
    hit.counterstop = (req.idx == csr_pkg::CSR_COUNTERSTOP); // Custom register
    // Machine information, read-only
    hit.mvendorid   = (req.idx == csr_pkg::CSR_MVENDORID);
    hit.marchid     = (req.idx == csr_pkg::CSR_MARCHID);
    hit.mimpid      = (req.idx == csr_pkg::CSR_MIMPID);
    hit.mhartid     = (req.idx == csr_pkg::CSR_MHARTID);
  end

  //////////////////////////////////////////////////////////////////////////
  // Enable gating

  // Unmapped index gives all-zero selects and so a zero read
  assign rd_sel = hit & {SEL_W{rd_go}};

  // Strobes for read-only CSRs exist but nothing consumes them
  assign wr_stb = hit & {SEL_W{wr_go}};

endmodule

//--- csr/csr_read_mux.sv
////////////////////////////////////////////////////////////////////////////
// CSR read path. AND-OR multiplexer over the register values and the
// constant identification registers, zero when no select is active
////////////////////////////////////////////////////////////////////////////

module csr_read_mux #(
  parameter int HART_ID_W = 1
) (
  input  csr_pkg::csr_sel_t    rd_sel,
  input  csr_pkg::xlen_t       mstatus,
  input  csr_pkg::xlen_t       mie,
  input  csr_pkg::xlen_t       mip,
  input  csr_pkg::xlen_t       mtvec,
  input  csr_pkg::xlen_t       mscratch,
  input  csr_pkg::xlen_t       mepc,
  input  csr_pkg::xlen_t       mcause,
  input  csr_pkg::xlen_t       mcycle,
  input  csr_pkg::xlen_t       mcycleh,
  input  csr_pkg::xlen_t       minstret,
  input  csr_pkg::xlen_t       minstreth,
  input  csr_pkg::xlen_t       counterstop,
  input  logic [HART_ID_W-1:0] hart_id,
  output csr_pkg::xlen_t       rdata
);

  localparam int W = csr_pkg::XLEN;

  csr_pkg::xlen_t mhartid;

  assign mhartid = {{(W-HART_ID_W){1'b0}}, hart_id};  // Zero-extended core id

  ////////////////////////////////////////////////////////////////////////////
  // One-hot AND-OR select

  assign rdata = ({W{rd_sel.mstatus    }} & mstatus               )
               | ({W{rd_sel.misa       }} & csr_pkg::MISA_VAL     )
               | ({W{rd_sel.mie        }} & mie                   )
               | ({W{rd_sel.mtvec      }} & mtvec                 )
               | ({W{rd_sel.mscratch   }} & mscratch              )
               | ({W{rd_sel.mepc       }} & mepc                  )
               | ({W{rd_sel.mcause     }} & mcause                )
               | ({W{rd_sel.mip        }} & mip                   )
               | ({W{rd_sel.mcycle     }} & mcycle                )
               | ({W{rd_sel.mcycleh    }} & mcycleh               )
               | ({W{rd_sel.minstret   }} & minstret              )
               | ({W{rd_sel.minstreth  }} & minstreth             )
               | ({W{rd_sel.counterstop}} & counterstop           ) // Custom
               | ({W{rd_sel.mvendorid  }} & csr_pkg::MVENDORID_VAL)
               | ({W{rd_sel.marchid    }} & csr_pkg::MARCHID_VAL  )
               | ({W{rd_sel.mimpid     }} & csr_pkg::MIMPID_VAL   )
               | ({W{rd_sel.mhartid    }} & mhartid               );

endmodule

//--- csr/csr_top.sv
////////////////////////////////////////////////////////////////////////////
// Machine-mode CSR file top level. Connects decode, trap registers,
// counters and the read multiplexer
////////////////////////////////////////////////////////////////////////////

module csr_top #(
  parameter int HART_ID_W = 1
) (
  input  logic                 clk,
  input  logic                 reset,
  input  csr_pkg::csr_req_t    req,
  input  csr_pkg::xlen_t       wdata,       // Write-back data
  input  csr_pkg::cmt_t        cmt,
  input  csr_pkg::irq_t        irq,
  input  logic [HART_ID_W-1:0] hart_id,
  output csr_pkg::xlen_t       rdata,       // Combinational read data
  output logic                 status_mie,  // Global interrupt enable
  output logic                 meie,
  output logic                 mtie,
  output logic                 msie,
  output csr_pkg::xlen_t       epc,
  output csr_pkg::xlen_t       mtvec,
  output logic                 tm_stop      // Stops the external timer
);

  csr_pkg::csr_sel_t rd_sel;
  csr_pkg::csr_sel_t wr_stb;
  csr_pkg::xlen_t    mstatus, mie, mip, mscratch, mepc, mcause;
  csr_pkg::xlen_t    mcycle, mcycleh, minstret, minstreth, counterstop;

  csr_decode u_decode (.req(req), .rd_sel(rd_sel), .wr_stb(wr_stb));

  csr_trap_regs u_trap_regs (
    .clk(clk), .reset(reset), .wr_stb(wr_stb), .wdata(wdata), .cmt(cmt), .irq(irq),
    .mstatus(mstatus), .mie(mie), .mip(mip), .mtvec(mtvec), .mscratch(mscratch),
    .mepc(mepc), .mcause(mcause)
  );

  csr_counters u_counters (
    .clk(clk), .reset(reset), .wr_stb(wr_stb), .wdata(wdata),
    .instret_ena(cmt.instret_ena), .mcycle(mcycle), .mcycleh(mcycleh),
    .minstret(minstret), .minstreth(minstreth), .counterstop(counterstop)
  );

  csr_read_mux #(.HART_ID_W(HART_ID_W)) u_read_mux (
    .rd_sel(rd_sel), .mstatus(mstatus), .mie(mie), .mip(mip), .mtvec(mtvec),
    .mscratch(mscratch), .mepc(mepc), .mcause(mcause), .mcycle(mcycle),
    .mcycleh(mcycleh), .minstret(minstret), .minstreth(minstreth),
    .counterstop(counterstop), .hart_id(hart_id), .rdata(rdata)
  );

  // Status bits to the core
  assign status_mie = mstatus[csr_pkg::MIE_BIT];
  assign meie       = mie[csr_pkg::MEI_BIT];
  assign mtie       = mie[csr_pkg::MTI_BIT];
  assign msie       = mie[csr_pkg::MSI_BIT];
  assign epc        = mepc;
  assign tm_stop    = counterstop[1];   // TIME stop bit

endmodule

//--- csr/csr_trap_regs.sv
////////////////////////////////////////////////////////////////////////////
// Trap and interrupt CSRs: mstatus, mie, mip, mtvec, mscratch, mepc and
// mcause. Commit events take priority over software writes
////////////////////////////////////////////////////////////////////////////

module csr_trap_regs (
  input  logic              clk,
  input  logic              reset,
  input  csr_pkg::csr_sel_t wr_stb,
  input  csr_pkg::xlen_t    wdata,
  input  csr_pkg::cmt_t     cmt,
  input  csr_pkg::irq_t     irq,
  output csr_pkg::xlen_t    mstatus,
  output csr_pkg::xlen_t    mie,
  output csr_pkg::xlen_t    mip,
  output csr_pkg::xlen_t    mtvec,
  output csr_pkg::xlen_t    mscratch,
  output csr_pkg::xlen_t    mepc,
  output csr_pkg::xlen_t    mcause
);

  logic           status_mie_q;
  logic           status_mpie_q;
  logic [2:0]     mie_q;            // {MEIE, MTIE, MSIE}
  logic [2:0]     mip_q;            // {MEIP, MTIP, MSIP}
  csr_pkg::xlen_t mtvec_q;
  csr_pkg::xlen_t mscratch_q;
  logic [31:1]    mepc_q;           // Bit 0 never stored
  logic           cause_irq_q;      // Interrupt flag
  logic [3:0]     cause_code_q;     // Exception code
  csr_pkg::xlen_t epc_nxt;
  csr_pkg::xlen_t cause_nxt;

  //////////////////////////////////////////////////////////////////////////
  // mstatus MIE and MPIE

  always_ff @(posedge clk) begin
    if (reset) begin
      status_mie_q  <= 1'b0;
      status_mpie_q <= 1'b0;
    end else if (cmt.trap_ena) begin   // Trap entry wins over MRET
      status_mpie_q <= status_mie_q;   // Save current enable
      status_mie_q  <= 1'b0;
    end else if (cmt.mret_ena) begin
      status_mie_q  <= status_mpie_q;  // Restore saved enable
      status_mpie_q <= 1'b1;
    end else if (wr_stb.mstatus) begin
      status_mie_q  <= wdata[csr_pkg::MIE_BIT];
      status_mpie_q <= wdata[csr_pkg::MPIE_BIT];
    end
  end

  // Pack the full register, machine mode only
  always_comb begin
    mstatus                    = '0;             // SD and FS/XS read as 0
    mstatus[12:11]             = 2'b11;          // MPP
    mstatus[csr_pkg::MPIE_BIT] = status_mpie_q;
    mstatus[csr_pkg::MIE_BIT]  = status_mie_q;
  end

  //////////////////////////////////////////////////////////////////////////
  // Plain registers, interrupt enables and pending lines

  // Commit value first, otherwise software data
  assign epc_nxt   = cmt.epc_ena   ? cmt.epc   : wdata;
  assign cause_nxt = cmt.cause_ena ? cmt.cause : wdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      mie_q        <= '0;
      mip_q        <= '0;
      mtvec_q      <= '0;
      mscratch_q   <= '0;
      mepc_q       <= '0;
      cause_irq_q  <= 1'b0;
      cause_code_q <= '0;
    end else begin
      mip_q <= {irq.ext, irq.tmr, irq.sft};  // Sampled every cycle
      if (wr_stb.mie) mie_q <= {wdata[csr_pkg::MEI_BIT], wdata[csr_pkg::MTI_BIT],
                                wdata[csr_pkg::MSI_BIT]};
      if (wr_stb.mtvec) mtvec_q <= wdata;
      if (wr_stb.mscratch) mscratch_q <= wdata;
      if (cmt.epc_ena | wr_stb.mepc) mepc_q <= epc_nxt[31:1];
      if (cmt.cause_ena | wr_stb.mcause) begin
        cause_irq_q  <= cause_nxt[31];
        cause_code_q <= cause_nxt[3:0];
      end
    end
  end

  always_comb begin
    mie                   = '0;
    mie[csr_pkg::MEI_BIT] = mie_q[2];
    mie[csr_pkg::MTI_BIT] = mie_q[1];
    mie[csr_pkg::MSI_BIT] = mie_q[0];
    mip                   = '0;          // Pending bits are read-only
    mip[csr_pkg::MEI_BIT] = mip_q[2];
    mip[csr_pkg::MTI_BIT] = mip_q[1];
    mip[csr_pkg::MSI_BIT] = mip_q[0];
  end

  assign mtvec    = mtvec_q;
  assign mscratch = mscratch_q;
  assign mepc     = {mepc_q, 1'b0};                  // Always halfword aligned
  assign mcause   = {cause_irq_q, 27'b0, cause_code_q};

endmodule

//--- flist.f
common/csr_pkg.sv
csr/csr_decode.sv
csr/csr_trap_regs.sv
csr/csr_counters.sv
csr/csr_read_mux.sv
csr/csr_top.sv
verif/csr_assert.sv
verif/csr_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the CSR testbench with Verilator, exit status gives the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module csr_tb -o csr_sim &&
./obj_dir/csr_sim +verilator+error+limit+1000 ||
exit 1

//--- verif/csr_assert.sv
////////////////////////////////////////////////////////////////////////////
// Concurrent checks on the CSR file, bound into csr_top. Expected values
// come from delayed copies of the port activity and a counterstop model
////////////////////////////////////////////////////////////////////////////

module csr_assert #(
  parameter int HART_ID_W = 1
) (
  input logic                 clk, reset, status_mie, meie, mtie, msie, tm_stop,
  input csr_pkg::csr_req_t    req,
  input csr_pkg::xlen_t       wdata, rdata, epc, mtvec,
  input csr_pkg::cmt_t        cmt,
  input csr_pkg::irq_t        irq,
  input logic [HART_ID_W-1:0] hart_id
);

  int                err_cnt = 0;           // Watched by the testbench
  logic              off;                   // Checks paused around reset
  logic              p1_reset, p1_mie;
  csr_pkg::csr_req_t p1_req, p2_req, p3_req;  // Request history
  csr_pkg::xlen_t    p1_wdata, p2_wdata, p1_rdata, p2_rdata, p3_rdata;
  csr_pkg::cmt_t     p1_cmt;
  csr_pkg::irq_t     p1_irq;
  logic [2:0]        cstop_m, p1_cstop;     // {IR, TM, CY} as written

  function automatic logic rd_at(csr_pkg::csr_req_t r, csr_pkg::csr_idx_t a);
    return r.ena & r.rd_en & (r.idx == a);
  endfunction

  function automatic logic wr_at(csr_pkg::csr_req_t r, csr_pkg::csr_idx_t a);
    return r.ena & r.wr_en & (r.idx == a);
  endfunction

  task automatic report_mismatch(input string what, input csr_pkg::xlen_t got,
                                 input csr_pkg::xlen_t exp);
    err_cnt++;
    $error("ERROR %s got=%h expected=%h", what, got, exp);
  endtask

  assign off = reset | p1_reset;

  always_ff @(posedge clk) begin
    p1_reset <= reset;
    p1_req   <= req;
    p2_req   <= p1_req;
    p3_req   <= p2_req;
    p1_wdata <= wdata;
    p2_wdata <= p1_wdata;
    p1_rdata <= rdata;
    p2_rdata <= p1_rdata;
    p3_rdata <= p2_rdata;
    p1_cmt   <= cmt;
    p1_irq   <= irq;
    p1_mie   <= status_mie;
    p1_cstop <= cstop_m;
    if (reset) cstop_m <= '0;
    else if (wr_at(req, csr_pkg::CSR_COUNTERSTOP)) cstop_m <= wdata[2:0];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Interrupt enables and mstatus

  a_mie_rd: assert property (@(posedge clk) disable iff (off) wr_at(p1_req, csr_pkg::CSR_MIE)
    && rd_at(req, csr_pkg::CSR_MIE) |-> rdata == (p1_wdata & 32'h0000_0888))
    else report_mismatch("mie", $sampled(rdata), $sampled(p1_wdata) & 32'h888);
  a_mie_out: assert property (@(posedge clk) disable iff (off) wr_at(p1_req, csr_pkg::CSR_MIE)
    |-> {meie, mtie, msie} == {p1_wdata[11], p1_wdata[7], p1_wdata[3]})
    else report_mismatch("meie_mtie_msie", $sampled({meie, mtie, msie}),
                         $sampled({p1_wdata[11], p1_wdata[7], p1_wdata[3]}));
  a_trap: assert property (@(posedge clk) disable iff (off) p1_cmt.trap_ena |-> !status_mie
    && (!rd_at(req, csr_pkg::CSR_MSTATUS) || rdata[7] == p1_mie))
    else report_mismatch("mstatus", $sampled(rdata), {24'b0, $sampled(p1_mie), 7'b0});
  a_mret_mie: assert property (@(posedge clk) disable iff (off) p1_cmt.mret_ena
    && !p1_cmt.trap_ena && rd_at(p1_req, csr_pkg::CSR_MSTATUS) |-> status_mie == p1_rdata[7])
    else report_mismatch("status_mie", $sampled(status_mie), $sampled(p1_rdata[7]));
  a_mret_mpie: assert property (@(posedge clk) disable iff (off) p1_cmt.mret_ena
    && !p1_cmt.trap_ena && rd_at(req, csr_pkg::CSR_MSTATUS) |-> rdata[7])
    else report_mismatch("mstatus.mpie", $sampled(rdata), 32'h80);
  a_mpp: assert property (@(posedge clk) disable iff (off)
    rd_at(req, csr_pkg::CSR_MSTATUS) |-> rdata[12:11] == 2'b11)
    else report_mismatch("mstatus.mpp", $sampled(rdata), 32'h1800);

  ////////////////////////////////////////////////////////////////////////////
  // Trap registers

  a_epc_cmt: assert property (@(posedge clk) disable iff (off)
    p1_cmt.epc_ena |-> epc == {p1_cmt.epc[31:1], 1'b0})
    else report_mismatch("epc", $sampled(epc), $sampled({p1_cmt.epc[31:1], 1'b0}));
  a_epc_wr: assert property (@(posedge clk) disable iff (off) wr_at(p1_req, csr_pkg::CSR_MEPC)
    && !p1_cmt.epc_ena |-> epc == {p1_wdata[31:1], 1'b0})
    else report_mismatch("epc", $sampled(epc), $sampled({p1_wdata[31:1], 1'b0}));
  a_mepc_rd: assert property (@(posedge clk) disable iff (off)
    rd_at(req, csr_pkg::CSR_MEPC) |-> rdata == epc && !rdata[0])
    else report_mismatch("mepc", $sampled(rdata), $sampled(epc));
  a_mcause: assert property (@(posedge clk) disable iff (off) rd_at(req, csr_pkg::CSR_MCAUSE)
    |-> (rdata & 32'h7FFF_FFF0) == '0
    && (!p1_cmt.cause_ena || rdata == (p1_cmt.cause & 32'h8000_000F)))
    else report_mismatch("mcause", $sampled(rdata),
                         $sampled((p1_cmt.cause_ena ? p1_cmt.cause : rdata) & 32'h8000_000F));
  a_mcause_wr: assert property (@(posedge clk) disable iff (off)
    wr_at(p1_req, csr_pkg::CSR_MCAUSE) && !p1_cmt.cause_ena && rd_at(req, csr_pkg::CSR_MCAUSE)
    |-> rdata == (p1_wdata & 32'h8000_000F))
    else report_mismatch("mcause", $sampled(rdata), $sampled(p1_wdata & 32'h8000_000F));
  a_mip: assert property (@(posedge clk) disable iff (off) rd_at(req, csr_pkg::CSR_MIP)
    |-> rdata == {20'b0, p1_irq.ext, 3'b0, p1_irq.tmr, 3'b0, p1_irq.sft, 3'b0})
    else report_mismatch("mip", $sampled(rdata),
                         $sampled({20'b0, p1_irq.ext, 3'b0, p1_irq.tmr, 3'b0, p1_irq.sft, 3'b0}));
  a_mtvec: assert property (@(posedge clk) disable iff (off)
    wr_at(p1_req, csr_pkg::CSR_MTVEC) |-> mtvec == p1_wdata)
    else report_mismatch("mtvec", $sampled(mtvec), $sampled(p1_wdata));
  a_mtvec_rd: assert property (@(posedge clk) disable iff (off)
    wr_at(p1_req, csr_pkg::CSR_MTVEC) && rd_at(req, csr_pkg::CSR_MTVEC) |-> rdata == p1_wdata)
    else report_mismatch("mtvec_rd", $sampled(rdata), $sampled(p1_wdata));
  a_mscratch: assert property (@(posedge clk) disable iff (off)
    wr_at(p1_req, csr_pkg::CSR_MSCRATCH) && rd_at(req, csr_pkg::CSR_MSCRATCH)
    |-> rdata == p1_wdata)
    else report_mismatch("mscratch", $sampled(rdata), $sampled(p1_wdata));

  ////////////////////////////////////////////////////////////////////////////
  // Counters, constants and idle reads

  a_mcycle: assert property (@(posedge clk) disable iff (off) rd_at(p1_req, csr_pkg::CSR_MCYCLE)
    && rd_at(req, csr_pkg::CSR_MCYCLE) |-> rdata == p1_rdata + {31'b0, !p1_cstop[0]})
    else report_mismatch("mcycle", $sampled(rdata),
                         $sampled(p1_rdata + {31'b0, !p1_cstop[0]}));
  a_carry: assert property (@(posedge clk) disable iff (off) rd_at(req, csr_pkg::CSR_MCYCLEH)
    && wr_at(p2_req, csr_pkg::CSR_MCYCLE) && p2_wdata == '1 && rd_at(p3_req, csr_pkg::CSR_MCYCLEH)
    && !p1_cstop[0] |-> rdata == p3_rdata + 32'd1)
    else report_mismatch("mcycleh", $sampled(rdata), $sampled(p3_rdata) + 32'd1);
  a_minstret: assert property (@(posedge clk) disable iff (off)
    rd_at(p1_req, csr_pkg::CSR_MINSTRET) && rd_at(req, csr_pkg::CSR_MINSTRET)
    |-> rdata == p1_rdata + {31'b0, p1_cmt.instret_ena & !p1_cstop[2]})
    else report_mismatch("minstret", $sampled(rdata),
                         $sampled(p1_rdata + {31'b0, p1_cmt.instret_ena & !p1_cstop[2]}));
  a_tm_stop: assert property (@(posedge clk) disable iff (off)
    wr_at(p1_req, csr_pkg::CSR_COUNTERSTOP) |-> tm_stop == p1_wdata[1])
    else report_mismatch("tm_stop", $sampled(tm_stop), $sampled(p1_wdata[1]));
  a_misa: assert property (@(posedge clk) disable iff (off)
    rd_at(req, csr_pkg::CSR_MISA) |-> rdata == csr_pkg::MISA_VAL)
    else report_mismatch("misa", $sampled(rdata), csr_pkg::MISA_VAL);
  a_mvendorid: assert property (@(posedge clk) disable iff (off)
    rd_at(req, csr_pkg::CSR_MVENDORID) |-> rdata == csr_pkg::MVENDORID_VAL)
    else report_mismatch("mvendorid", $sampled(rdata), csr_pkg::MVENDORID_VAL);
  a_marchid: assert property (@(posedge clk) disable iff (off)
    rd_at(req, csr_pkg::CSR_MARCHID) |-> rdata == csr_pkg::MARCHID_VAL)
    else report_mismatch("marchid", $sampled(rdata), csr_pkg::MARCHID_VAL);
  a_mimpid: assert property (@(posedge clk) disable iff (off)
    rd_at(req, csr_pkg::CSR_MIMPID) |-> rdata == csr_pkg::MIMPID_VAL)
    else report_mismatch("mimpid", $sampled(rdata), csr_pkg::MIMPID_VAL);
  a_hartid: assert property (@(posedge clk) disable iff (off)
    rd_at(req, csr_pkg::CSR_MHARTID) |-> rdata == 32'(hart_id))
    else report_mismatch("mhartid", $sampled(rdata), 32'($sampled(hart_id)));
  a_idle: assert property (@(posedge clk) disable iff (off) !(req.ena && req.rd_en)
    || req.idx == 12'h7C0 |-> rdata == '0)
    else report_mismatch("rdata_idle", $sampled(rdata), '0);

endmodule

bind csr_top csr_assert #(.HART_ID_W(HART_ID_W)) u_chk (
  .clk(clk), .reset(reset), .status_mie(status_mie), .meie(meie), .mtie(mtie),
  .msie(msie), .tm_stop(tm_stop), .req(req), .wdata(wdata), .rdata(rdata),
  .epc(epc), .mtvec(mtvec), .cmt(cmt), .irq(irq), .hart_id(hart_id)
);

//--- verif/csr_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the CSR file. Drives accesses, commits and interrupt
// lines on the falling edge, the bound checker does the comparing
////////////////////////////////////////////////////////////////////////////

module csr_tb;

  localparam int HART_ID_W   = 4;
  localparam int TEST_CYCLES = 76;    // Negedges in the sequence below including reset

  logic              clk, reset, status_mie, meie, mtie, msie, tm_stop;
  csr_pkg::csr_req_t req;
  csr_pkg::xlen_t    wdata, rdata, epc, mtvec;
  csr_pkg::cmt_t     cmt;
  csr_pkg::irq_t     irq;
  logic [HART_ID_W-1:0] hart_id;

  csr_top #(.HART_ID_W(HART_ID_W)) u_dut (
    .clk(clk), .reset(reset), .req(req), .wdata(wdata), .cmt(cmt), .irq(irq),
    .hart_id(hart_id), .rdata(rdata), .status_mie(status_mie), .meie(meie),
    .mtie(mtie), .msie(msie), .epc(epc), .mtvec(mtvec), .tm_stop(tm_stop)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin                          // Watchdog
    #(TEST_CYCLES * 20 * 2);
    $display("Testbench failed");
    $fatal(1, "Simulation did not finish in time");
  end

  always @(negedge clk) begin            // Stop on the first failed assertion
    if (u_dut.u_chk.err_cnt != 0) begin
      $display("Testbench failed");
      $fatal(1, "Assertion check failed");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // One-cycle stimulus tasks

  task automatic csr_access(input logic wr, input logic rd, input csr_pkg::csr_idx_t idx,
                            input csr_pkg::xlen_t data);
    @(negedge clk);
    req   = '{ena: 1'b1, wr_en: wr, rd_en: rd, idx: idx};
    wdata = data;
    cmt   = '0;
  endtask

  task automatic csr_write(input csr_pkg::csr_idx_t idx, input csr_pkg::xlen_t data);
    csr_access(1'b1, 1'b0, idx, data);
  endtask

  task automatic csr_read(input csr_pkg::csr_idx_t idx);
    csr_access(1'b0, 1'b1, idx, $urandom);
  endtask

  // Trap entry with a competing software write on the same edge
  task automatic trap_commit(input csr_pkg::csr_idx_t wr_idx);
    csr_write(wr_idx, $urandom);
    cmt.trap_ena  = 1'b1;
    cmt.epc_ena   = 1'b1;
    cmt.epc       = $urandom;
    cmt.cause_ena = 1'b1;
    cmt.cause     = $urandom;
  endtask

  task automatic mret_read();
    csr_read(csr_pkg::CSR_MSTATUS);      // Old MPIE seen on rdata
    cmt.mret_ena = 1'b1;
  endtask

  task automatic instret_pulses(input int n);
    repeat (n) begin
      csr_read(csr_pkg::CSR_MINSTRET);
      cmt.instret_ena = 1'($urandom);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    void'($urandom(32'h73b9_89ad));
    reset   = 1'b1;
    req     = '0;
    wdata   = '0;
    cmt     = '0;
    irq     = '0;
    hart_id = 4'hA;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    repeat (4) begin                     // mie masking
      csr_write(csr_pkg::CSR_MIE, $urandom);
      csr_read(csr_pkg::CSR_MIE);
    end
    csr_write(csr_pkg::CSR_MSTATUS, 32'h8);
    csr_read(csr_pkg::CSR_MSTATUS);
    trap_commit(csr_pkg::CSR_MEPC);
    csr_read(csr_pkg::CSR_MSTATUS);
    mret_read();
    csr_read(csr_pkg::CSR_MSTATUS);
    trap_commit(csr_pkg::CSR_MCAUSE);    // MIE set again by MRET
    csr_read(csr_pkg::CSR_MCAUSE);
    csr_read(csr_pkg::CSR_MEPC);
    csr_write(csr_pkg::CSR_MEPC, $urandom);
    csr_read(csr_pkg::CSR_MEPC);
    csr_write(csr_pkg::CSR_MCAUSE, $urandom);
    csr_read(csr_pkg::CSR_MCAUSE);
    repeat (6) begin                     // Pending lines one cycle late
      csr_read(csr_pkg::CSR_MIP);
      irq = 3'($urandom);
    end
    csr_write(csr_pkg::CSR_MTVEC, $urandom);
    csr_read(csr_pkg::CSR_MTVEC);
    csr_write(csr_pkg::CSR_MSCRATCH, $urandom);
    csr_read(csr_pkg::CSR_MSCRATCH);
    repeat (3) csr_read(csr_pkg::CSR_MCYCLE);
    csr_write(csr_pkg::CSR_COUNTERSTOP, 32'h1);
    repeat (3) csr_read(csr_pkg::CSR_MCYCLE);
    csr_write(csr_pkg::CSR_COUNTERSTOP, 32'h2);
    csr_read(csr_pkg::CSR_MCYCLEH);      // Carry into the high half
    csr_write(csr_pkg::CSR_MCYCLE, 32'hFFFF_FFFF);
    csr_read(csr_pkg::CSR_MSTATUS);
    csr_read(csr_pkg::CSR_MCYCLEH);
    instret_pulses(10);
    csr_write(csr_pkg::CSR_COUNTERSTOP, 32'h4);
    instret_pulses(6);
    csr_write(csr_pkg::CSR_COUNTERSTOP, 32'h0);
    csr_read(csr_pkg::CSR_MISA);
    csr_read(csr_pkg::CSR_MVENDORID);
    csr_read(csr_pkg::CSR_MARCHID);
    csr_read(csr_pkg::CSR_MIMPID);
    csr_read(csr_pkg::CSR_MHARTID);
    csr_read(12'h7C0);                   // Unmapped
    csr_access(1'b0, 1'b0, csr_pkg::CSR_MISA, '0);
    repeat (3) @(negedge clk);
    if (u_dut.u_chk.err_cnt == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("Testbench failed");
      $fatal(1, "Assertion check failed");
    end
  end

endmodule
